/* rtl/minx_io_pkg.sv */
`default_nettype none

package minx_io_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [3:0]  reg_offset_t;
    typedef logic [15:0] count_t;
    typedef logic [2:0]  irq_vec_t;

    // Timer0 underflow, timer0 compare, timer1 underflow, timer1 compare, key 0, key 1.
    localparam int IRQ_SOURCES = 6;

    typedef enum logic [1:0]
    {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    // Region is picked by the upper address nibble.
    localparam reg_addr_t REGION_TMR0 = 8'h00;
    localparam reg_addr_t REGION_TMR1 = 8'h10;
    localparam reg_addr_t REGION_IRQ  = 8'h20;

    ////////////////////////////////////////////////////////////////////////////
    // Timer registers
    localparam reg_offset_t TMR_CTRL      = 4'h0;
    localparam reg_offset_t TMR_PRE       = 4'h1;
    localparam reg_offset_t TMR_PRESET_LO = 4'h2;
    localparam reg_offset_t TMR_PRESET_HI = 4'h3;
    localparam reg_offset_t TMR_CMP_LO    = 4'h4;
    localparam reg_offset_t TMR_CMP_HI    = 4'h5;
    localparam reg_offset_t TMR_CNT_LO    = 4'h6; // Read-only.
    localparam reg_offset_t TMR_CNT_HI    = 4'h7; // Read-only.

    localparam int TMR_CTRL_ENABLE_BIT = 0;
    localparam int TMR_CTRL_RELOAD_BIT = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt controller registers
    localparam reg_offset_t IRQ_ENABLE  = 4'h0;
    localparam reg_offset_t IRQ_PENDING = 4'h1; // Write 1 to clear.
    localparam reg_offset_t IRQ_VECTOR  = 4'h2; // Read-only.

    localparam int IRQ_VECTOR_VALID_BIT = 7;

endpackage

`default_nettype wire

/* rtl/periph_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
    import minx_io_pkg::*;

    logic        sel;    // Region addressed in the access cycle.
    logic        wr_en;  // Single-cycle write strobe.
    reg_offset_t offset;
    reg_data_t   wdata;
    reg_data_t   rdata;  // Combinational read at offset.
    logic        hit;    // Offset is a defined register.

    modport master
    (
        output sel,
        output wr_en,
        output offset,
        output wdata,
        input  rdata,
        input  hit
    );

    modport slave
    (
        input  sel,
        input  wr_en,
        input  offset,
        input  wdata,
        output rdata,
        output hit
    );

endinterface

`default_nettype wire

/* rtl/apb_register_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_register_port
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire minx_io_pkg::reg_addr_t paddr,
    input  wire minx_io_pkg::reg_data_t pwdata,
    output minx_io_pkg::reg_data_t      prdata,
    output logic                        pready,
    output logic                        pslverr,
    periph_bus_if.master                tmr0_bus,
    periph_bus_if.master                tmr1_bus,
    periph_bus_if.master                irq_bus
);
    import minx_io_pkg::*;

    apb_state_t  phase;
    apb_state_t  state_q;
    logic        access_ok;
    logic [3:0]  region;
    logic        is_tmr0;
    logic        is_tmr1;
    logic        is_irq;
    logic        region_ok;
    logic        slave_hit;
    reg_data_t   slave_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Protocol tracking
    always_comb
    begin
        if (!psel)
            phase = APB_IDLE;
        else if (!penable)
            phase = APB_SETUP;
        else
            phase = APB_ACCESS;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= APB_IDLE;
        else
            state_q <= phase;
    end

    // An access phase only counts when a setup phase came right before it.
    assign access_ok = (phase == APB_ACCESS) && (state_q == APB_SETUP);
    assign pready    = (phase == APB_ACCESS);

    ////////////////////////////////////////////////////////////////////////////
    // Region decode
    assign region  = paddr[7:4];
    assign is_tmr0 = (region == REGION_TMR0[7:4]);
    assign is_tmr1 = (region == REGION_TMR1[7:4]);
    assign is_irq  = (region == REGION_IRQ[7:4]);

    assign tmr0_bus.sel    = access_ok && is_tmr0;
    assign tmr0_bus.wr_en  = tmr0_bus.sel && pwrite;
    assign tmr0_bus.offset = paddr[3:0];
    assign tmr0_bus.wdata  = pwdata;

    assign tmr1_bus.sel    = access_ok && is_tmr1;
    assign tmr1_bus.wr_en  = tmr1_bus.sel && pwrite;
    assign tmr1_bus.offset = paddr[3:0];
    assign tmr1_bus.wdata  = pwdata;

    assign irq_bus.sel     = access_ok && is_irq;
    assign irq_bus.wr_en   = irq_bus.sel && pwrite;
    assign irq_bus.offset  = paddr[3:0];
    assign irq_bus.wdata   = pwdata;

    always_comb
    begin
        region_ok   = 1'b1;
        slave_hit   = 1'b0;
        slave_rdata = '0;
        if (is_tmr0)
        begin
            slave_hit   = tmr0_bus.hit;
            slave_rdata = tmr0_bus.rdata;
        end
        else if (is_tmr1)
        begin
            slave_hit   = tmr1_bus.hit;
            slave_rdata = tmr1_bus.rdata;
        end
        else if (is_irq)
        begin
            slave_hit   = irq_bus.hit;
            slave_rdata = irq_bus.rdata;
        end
        else
            region_ok = 1'b0;
    end

    // Unknown regions and undefined offsets read zero with an error.
    assign prdata  = (access_ok && region_ok && slave_hit) ? slave_rdata : '0;
    assign pslverr = access_ok && !(region_ok && slave_hit);

endmodule

`default_nettype wire

/* rtl/prescaled_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module prescaled_timer
#(
    parameter int PRE_WIDTH = 8
)
(
    input  wire         clk,
    input  wire         rst_n,
    periph_bus_if.slave bus,
    output logic        underflow,
    output logic        compare_match,
    output logic        timer_out
);
    import minx_io_pkg::*;

    logic                 enable_q;
    logic [PRE_WIDTH-1:0] pre_q;
    logic [PRE_WIDTH-1:0] presc_cnt;
    count_t               preset_q;
    count_t               cmp_q;
    count_t               count_q;
    count_t               count_next;
    logic                 tick;
    logic                 wr_ctrl;
    logic                 wr_pre;
    logic                 reload;

    assign wr_ctrl = bus.wr_en && (bus.offset == TMR_CTRL);
    assign wr_pre  = bus.wr_en && (bus.offset == TMR_PRE);
    assign reload  = wr_ctrl && bus.wdata[TMR_CTRL_RELOAD_BIT];

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            enable_q <= 1'b0;
            pre_q    <= '0;
            preset_q <= '0;
            cmp_q    <= '0;
        end
        else if (bus.wr_en)
        begin
            case (bus.offset)
                TMR_CTRL:      enable_q       <= bus.wdata[TMR_CTRL_ENABLE_BIT];
                TMR_PRE:       pre_q          <= bus.wdata[PRE_WIDTH-1:0];
                TMR_PRESET_LO: preset_q[7:0]  <= bus.wdata;
                TMR_PRESET_HI: preset_q[15:8] <= bus.wdata;
                TMR_CMP_LO:    cmp_q[7:0]     <= bus.wdata;
                TMR_CMP_HI:    cmp_q[15:8]    <= bus.wdata;
                default:       ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Prescaler and counter
    assign tick = enable_q && (presc_cnt == pre_q); // One tick per PRE+1 cycles.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            presc_cnt <= '0;
        else if (wr_pre || wr_ctrl)
            presc_cnt <= '0;
        else if (tick)
            presc_cnt <= '0;
        else if (enable_q)
            presc_cnt <= presc_cnt + 1'b1;
    end

    assign count_next = (count_q == '0) ? preset_q : count_q - 1'b1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            count_q <= '0;
        else if (reload)
            count_q <= preset_q; // Reload works even while stopped.
        else if (tick)
            count_q <= count_next;
    end

    assign underflow     = tick && (count_q == '0);
    assign compare_match = tick && (count_next == cmp_q);

    // Square wave output, one edge per underflow.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            timer_out <= 1'b0;
        else if (underflow)
            timer_out <= ~timer_out;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback
    always_comb
    begin
        bus.hit   = 1'b1;
        bus.rdata = '0;
        case (bus.offset)
            TMR_CTRL:      bus.rdata[TMR_CTRL_ENABLE_BIT] = enable_q;
            TMR_PRE:       bus.rdata = reg_data_t'(pre_q);
            TMR_PRESET_LO: bus.rdata = preset_q[7:0];
            TMR_PRESET_HI: bus.rdata = preset_q[15:8];
            TMR_CMP_LO:    bus.rdata = cmp_q[7:0];
            TMR_CMP_HI:    bus.rdata = cmp_q[15:8];
            TMR_CNT_LO:    bus.rdata = count_q[7:0];
            TMR_CNT_HI:    bus.rdata = count_q[15:8];
            default:       bus.hit   = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/irq_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_controller
(
    input  wire                   clk,
    input  wire                   rst_n,
    periph_bus_if.slave           bus,
    input  wire [3:0]             timer_events, // {t1 cmp, t1 uf, t0 cmp, t0 uf}.
    input  wire [1:0]             ext_irq,
    output logic                  cpu_irq,
    output minx_io_pkg::irq_vec_t irq_vector,
    output logic                  irq_valid
);
    import minx_io_pkg::*;

    logic [1:0]             ext_meta;
    logic [1:0]             ext_sync;
    logic [1:0]             ext_prev;
    logic [1:0]             ext_rise;
    logic [IRQ_SOURCES-1:0] sources;
    logic [IRQ_SOURCES-1:0] pending_q;
    logic [IRQ_SOURCES-1:0] enable_q;
    logic [IRQ_SOURCES-1:0] active;
    logic [IRQ_SOURCES-1:0] clear_mask;

    ////////////////////////////////////////////////////////////////////////////
    // Key inputs
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ext_meta <= '0;
            ext_sync <= '0;
            ext_prev <= '0;
        end
        else
        begin
            ext_meta <= ext_irq;
            ext_sync <= ext_meta;
            ext_prev <= ext_sync;
        end
    end

    assign ext_rise = ext_sync & ~ext_prev; // Rising edges only.
    assign sources  = {ext_rise, timer_events};

    ////////////////////////////////////////////////////////////////////////////
    // Pending and enable
    always_comb
    begin
        clear_mask = '0;
        if (bus.wr_en && (bus.offset == IRQ_PENDING))
            clear_mask = bus.wdata[IRQ_SOURCES-1:0];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pending_q <= '0;
        else
            pending_q <= (pending_q & ~clear_mask) | sources; // New events win over clears.
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            enable_q <= '0;
        else if (bus.wr_en && (bus.offset == IRQ_ENABLE))
            enable_q <= bus.wdata[IRQ_SOURCES-1:0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Priority
    assign active  = pending_q & enable_q;
    assign cpu_irq = |active;

    // Lowest index has the highest priority.
    always_comb
    begin
        irq_vector = '0;
        irq_valid  = 1'b0;
        for (int i = IRQ_SOURCES - 1; i >= 0; i--)
        begin
            if (active[i])
            begin
                irq_vector = irq_vec_t'(i);
                irq_valid  = 1'b1;
            end
        end
    end

    always_comb
    begin
        bus.hit   = 1'b1;
        bus.rdata = '0;
        case (bus.offset)
            IRQ_ENABLE:  bus.rdata = reg_data_t'(enable_q);
            IRQ_PENDING: bus.rdata = reg_data_t'(pending_q);
            IRQ_VECTOR:
            begin
                bus.rdata[IRQ_VECTOR_VALID_BIT] = irq_valid;
                bus.rdata[2:0]                  = irq_vector;
            end
            default:     bus.hit   = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/minx_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module minx_io_top
#(
    parameter int PRE_WIDTH = 8
)
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire minx_io_pkg::reg_addr_t paddr,
    input  wire minx_io_pkg::reg_data_t pwdata,
    output minx_io_pkg::reg_data_t      prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  wire [1:0]                   ext_irq,
    output logic                        cpu_irq,
    output minx_io_pkg::irq_vec_t       irq_vector,
    output logic [1:0]                  timer_out
);

    logic tmr0_underflow;
    logic tmr0_compare;
    logic tmr1_underflow;
    logic tmr1_compare;

    periph_bus_if tmr0_bus ();
    periph_bus_if tmr1_bus ();
    periph_bus_if irq_bus ();

    apb_register_port i_apb_register_port
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .tmr0_bus (tmr0_bus.master),
        .tmr1_bus (tmr1_bus.master),
        .irq_bus  (irq_bus.master)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Timers
    prescaled_timer #(.PRE_WIDTH(PRE_WIDTH)) i_timer0
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (tmr0_bus.slave),
        .underflow     (tmr0_underflow),
        .compare_match (tmr0_compare),
        .timer_out     (timer_out[0])
    );

    prescaled_timer #(.PRE_WIDTH(PRE_WIDTH)) i_timer1
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (tmr1_bus.slave),
        .underflow     (tmr1_underflow),
        .compare_match (tmr1_compare),
        .timer_out     (timer_out[1])
    );

    irq_controller i_irq_controller
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (irq_bus.slave),
        .timer_events ({tmr1_compare, tmr1_underflow, tmr0_compare, tmr0_underflow}),
        .ext_irq      (ext_irq),
        .cpu_irq      (cpu_irq),
        .irq_vector   (irq_vector),
        .irq_valid    ()             // Valid flag is read through IRQ_VECTOR.
    );

endmodule

`default_nettype wire

/* tb/minx_io_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module minx_io_checker
#(
    parameter int PRE_WIDTH = 8
)
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       psel,
    input  wire       penable,
    input  wire       pwrite,
    input  wire [7:0] paddr,
    input  wire [7:0] pwdata,
    input  wire [7:0] prdata,
    input  wire       pready,
    input  wire       pslverr,
    input  wire       cpu_irq,
    input  wire [2:0] irq_vector,
    input  wire       events_quiet, // No timer or key event can arrive.
    output int        check_count,
    output int        fail_count
);

    localparam logic [7:0] PRE_MASK = 8'((1 << PRE_WIDTH) - 1);

    logic        tmr_en [2];
    logic [7:0]  tmr_pre [2];
    logic [15:0] tmr_preset [2];
    logic [15:0] tmr_cmp [2];
    logic [15:0] cnt_model [2];
    logic        cnt_known [2];
    logic [5:0]  irq_en;
    logic [5:0]  pend_model;
    logic        pend_known;

    initial
    begin
        check_count = 0;
        fail_count  = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            fail_count++;
            $display("Fail at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    function automatic int lowest_index(input logic [5:0] active);
        for (int i = 0; i < 6; i++)
        begin
            if (active[i])
                return i;
        end
        return 0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One APB access cycle against the register model
    task automatic check_access();
        logic [3:0] region;
        logic [3:0] off;
        logic       valid;
        logic       known;
        logic [7:0] exp;
        int         t;
        region = paddr[7:4];
        off    = paddr[3:0];
        t      = region[0];
        valid  = ((region < 2) && (off < 8)) || ((region == 2) && (off < 3));
        known  = 1'b1;
        exp    = 8'h00;
        compare("pslverr", !valid, pslverr);
        if (!valid)
            compare("prdata", 0, prdata);
        else if (!pwrite)
        begin
            if (region < 2)
            begin
                case (off)
                    4'd0: exp = {7'b0, tmr_en[t]}; // Reload bit reads 0.
                    4'd1: exp = tmr_pre[t];
                    4'd2: exp = tmr_preset[t][7:0];
                    4'd3: exp = tmr_preset[t][15:8];
                    4'd4: exp = tmr_cmp[t][7:0];
                    4'd5: exp = tmr_cmp[t][15:8];
                    4'd6: exp = cnt_model[t][7:0];
                    default: exp = cnt_model[t][15:8];
                endcase
                if (off >= 6)
                    known = cnt_known[t];
            end
            else if (off == 0)
                exp = {2'b00, irq_en};
            else if (off == 1)
            begin
                known = pend_known;
                exp   = {2'b00, pend_model};
                compare("pending upper bits", 0, prdata[7:6]);
                compare("cpu_irq", |(prdata[5:0] & irq_en), cpu_irq);
                if (|(prdata[5:0] & irq_en))
                    compare("irq_vector", lowest_index(prdata[5:0] & irq_en), irq_vector);
            end
            else
            begin
                known = pend_known;
                exp   = 8'h00;
                if (|(pend_model & irq_en))
                    exp = 8'h80 | 8'(lowest_index(pend_model & irq_en));
            end
            if (known)
                compare($sformatf("prdata[%02h]", paddr), exp, prdata);
            if (region == 2 && off == 1)
            begin
                pend_model = prdata[5:0];
                pend_known = events_quiet;
            end
        end
        else if (region < 2)
        begin
            case (off)
                4'd0:
                begin
                    tmr_en[t] = pwdata[0];
                    if (pwdata[1])
                    begin
                        cnt_model[t] = tmr_preset[t];
                        cnt_known[t] = !pwdata[0];
                    end
                    else if (pwdata[0])
                        cnt_known[t] = 1'b0; // Count runs from here on.
                end
                4'd1: tmr_pre[t] = pwdata & PRE_MASK;
                4'd2: tmr_preset[t][7:0] = pwdata;
                4'd3: tmr_preset[t][15:8] = pwdata;
                4'd4: tmr_cmp[t][7:0] = pwdata;
                4'd5: tmr_cmp[t][15:8] = pwdata;
                default: ;
            endcase
        end
        else if (off == 0)
            irq_en = pwdata[5:0];
        else if (off == 1)
            pend_model = pend_model & ~pwdata[5:0];
    endtask

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 2; i++)
            begin
                tmr_en[i]     = 1'b0;
                tmr_pre[i]    = 8'h00;
                tmr_preset[i] = 16'h0000;
                tmr_cmp[i]    = 16'h0000;
                cnt_model[i]  = 16'h0000;
                cnt_known[i]  = 1'b1;
            end
            irq_en     = '0;
            pend_model = '0;
            pend_known = 1'b1;
        end
        else
        begin
            if (!events_quiet)
                pend_known = 1'b0;
            if (psel && penable)
            begin
                compare("pready", 1, pready);
                check_access();
            end
            else
                compare("pslverr outside access", 0, pslverr);
        end
    end

endmodule

`default_nettype wire

/* tb/tb_minx_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_minx_io;

    localparam int PRE_WIDTH   = 6;
    localparam int CLK_PERIOD  = 20;
    localparam int APB_TIMEOUT = 10;

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    logic [7:0] pwdata;
    logic [1:0] ext_irq;
    logic       events_quiet;
    wire  [7:0] prdata;
    wire        pready;
    wire        pslverr;
    wire        cpu_irq;
    wire  [2:0] irq_vector;
    wire  [1:0] timer_out;
    int         check_count;
    int         fail_count;
    int         tb_checks = 0;
    int         tb_fails = 0;
    int         fails_before = 0;
    int         cycle_count = 0;
    logic [1:0] tout_prev = 2'b00;
    int         tout_edges [2] = '{0, 0};

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle_count++;

    // Edges seen on each timer output.
    always @(negedge clk)
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (timer_out[i] !== tout_prev[i])
                tout_edges[i]++;
        end
        tout_prev = timer_out;
    end

    minx_io_top #(.PRE_WIDTH(PRE_WIDTH)) i_minx_io_top
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ext_irq    (ext_irq),
        .cpu_irq    (cpu_irq),
        .irq_vector (irq_vector),
        .timer_out  (timer_out)
    );

    minx_io_checker #(.PRE_WIDTH(PRE_WIDTH)) i_checker
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .cpu_irq      (cpu_irq),
        .irq_vector   (irq_vector),
        .events_quiet (events_quiet),
        .check_count  (check_count),
        .fail_count   (fail_count)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished, %0d failures", name, fail_count + tb_fails - fails_before);
        fails_before = fail_count + tb_fails;
    endtask

    task automatic check_signal(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        tb_checks++;
        if (expected !== actual)
        begin
            tb_fails++;
            $display("Fail at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB driver
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [7:0] data, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1; // Setup cycle.
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        while (!pready)
        begin
            waited++;
            if (waited > APB_TIMEOUT)
                abort_run("APB access cycle never saw pready high");
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
        apb_transfer(1'b0, addr, 8'h00, data);
    endtask

    task automatic pulse_ext(input logic [1:0] bits);
        @(negedge clk);
        ext_irq = bits;
        idle_cycles(2);
        ext_irq = 2'b00;
    endtask

    // Loads a timer, runs it and polls its underflow pending bit.
    task automatic run_timer(input int t, input int pre, input logic [15:0] preset,
                             input logic [15:0] cmp, input bit check_order);
        logic [7:0] base;
        logic [7:0] d;
        int         bound;
        int         start;
        int         edges_before;
        bit         cmp_first;
        base = (t == 1) ? 8'h10 : 8'h00;
        apb_write(base + 8'h1, 8'(pre));
        apb_write(base + 8'h2, preset[7:0]);
        apb_write(base + 8'h3, preset[15:8]);
        apb_write(base + 8'h4, cmp[7:0]);
        apb_write(base + 8'h5, cmp[15:8]);
        apb_write(base, 8'h02);   // Reload while stopped.
        apb_read(base + 8'h6, d);
        apb_read(base + 8'h7, d);
        apb_write(8'h21, 8'h3F);
        apb_write(base, 8'h01);
        bound        = (int'(preset) + 1) * ((pre & ((1 << PRE_WIDTH) - 1)) + 1) + 40;
        start        = cycle_count;
        edges_before = tout_edges[t];
        cmp_first    = 1'b0;
        d            = 8'h00;
        while (!d[2 * t])
        begin
            if (cycle_count - start > bound)
                abort_run($sformatf("Timer %0d underflow pending not set within %0d cycles",
                                    t, bound));
            apb_read(8'h21, d);
            if (d[2 * t + 1] && !d[2 * t])
                cmp_first = 1'b1;
        end
        if (check_order)
        begin
            tb_checks++;
            if (!cmp_first)
            begin
                tb_fails++;
                $display("Timer %0d compare pending was not seen before its underflow pending", t);
            end
        end
        tb_checks++;
        if (tout_edges[t] == edges_before)
        begin
            tb_fails++;
            $display("Timer %0d underflow did not toggle timer_out", t);
        end
        apb_write(base, 8'h00);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial
    begin
        logic [7:0]  addr;
        logic [7:0]  d;
        logic [3:0]  region;
        logic [3:0]  off;
        logic [15:0] preset;
        int          sel;
        int          passes;
        int          fails;
        void'($urandom(81849));
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 8'h00;
        pwdata       = 8'h00;
        ext_irq      = 2'b00;
        events_quiet = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_signal("timer_out", 8'h00, timer_out);
        check_signal("cpu_irq", 8'h00, cpu_irq);

        repeat (24)
        begin
            sel  = $urandom % 6;
            addr = (sel == 5) ? 8'h20 : (($urandom & 1) ? 8'h10 : 8'h00) + 8'(sel + 1);
            apb_write(addr, 8'($urandom));
            apb_read(addr, d);
        end
        apb_write(8'h00, 8'h02);
        apb_read(8'h00, d);
        apb_write(8'h10, 8'h02);
        apb_read(8'h10, d);
        finish_test("register readback");

        repeat (12)
        begin
            region = 4'($urandom);
            if (region < 2)
                off = 4'(8 + $urandom % 8);
            else if (region == 2)
                off = 4'(3 + $urandom % 13);
            else
                off = 4'($urandom);
            apb_write({region, off}, 8'($urandom));
            apb_read({region, off}, d);
            for (int a = 0; a < 6; a++)
            begin
                apb_read(8'(a), d);
                apb_read(8'h10 + 8'(a), d);
            end
            apb_read(8'h20, d);
        end
        finish_test("unmapped access");

        for (int t = 0; t < 2; t++)
            run_timer(t, $urandom % 8, 16'($urandom % 256), 16'h0000, 1'b0);
        finish_test("timer underflow");

        for (int t = 0; t < 2; t++)
        begin
            preset = 16'(20 + $urandom % 180);
            run_timer(t, $urandom % 4, preset, 16'(2 + $urandom % (preset - 2)), 1'b1);
        end
        finish_test("compare event");

        repeat (8)
        begin
            events_quiet = 1'b0;
            apb_write(8'h20, 8'($urandom & 8'h3F));
            apb_write(8'h21, 8'h3F);
            for (int t = 0; t < 2; t++)
            begin
                addr = (t == 1) ? 8'h10 : 8'h00;
                apb_write(addr + 8'h1, 8'($urandom % 4));
                apb_write(addr + 8'h2, 8'($urandom % 16));
                apb_write(addr + 8'h3, 8'h00);
                apb_write(addr + 8'h4, 8'($urandom % 16));
                apb_write(addr + 8'h5, 8'h00);
                apb_write(addr, 8'h03); // Reload and run.
            end
            pulse_ext(2'($urandom));
            idle_cycles(10 + $urandom % 30);
            apb_write(8'h00, 8'h00);
            apb_write(8'h10, 8'h00);
            idle_cycles(5);           // Key synchronizer settles.
            events_quiet = 1'b1;
            apb_read(8'h21, d);
            apb_read(8'h22, d);
        end
        finish_test("interrupt combining");

        events_quiet = 1'b0;
        apb_write(8'h20, 8'($urandom & 8'h3F) | 8'h10);
        pulse_ext(2'b11);
        idle_cycles(5);
        events_quiet = 1'b1;
        apb_read(8'h21, d);
        repeat (8)
        begin
            apb_write(8'h21, 8'($urandom & 8'h3F));
            apb_read(8'h21, d);
            apb_read(8'h22, d);
        end
        apb_write(8'h21, 8'h3F);
        apb_read(8'h21, d);
        check_signal("cpu_irq", 8'h00, cpu_irq);
        finish_test("write-1-to-clear");

        idle_cycles(2);
        fails  = fail_count + tb_fails;
        passes = check_count + tb_checks - fails;
        $display("Checks passed: %0d, checks failed: %0d", passes, fails);
        if (fails == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/minx_io_pkg.sv
rtl/periph_bus_if.sv
rtl/apb_register_port.sv
rtl/prescaled_timer.sv
rtl/irq_controller.sv
rtl/minx_io_top.sv
tb/minx_io_checker.sv
tb/tb_minx_io.sv
